// ==== design/bicg_cfg.svh ====
`ifndef BICG_CFG_SVH
`define BICG_CFG_SVH

// ##############################
// kernel sizing
// ##############################

// matrix order, A is N x N
`define BICG_N 8

// datapath word width
`define BICG_DATA_W 32

// ##############################
// memory addressing
// ##############################

// A memory holds N*N words, row-major
`define BICG_A_AW 6

// p and r memories hold N words each
`define BICG_V_AW 3

// load port addresses the widest memory
`define BICG_LOAD_AW `BICG_A_AW

`endif

// ==== design/bicg_pkg.sv ====
`include "bicg_cfg.svh"

package bicg_pkg;

    // ##############################
    // load port
    // ##############################

    // target memory of a host write
    typedef enum logic [1:0]
    {
        MEM_A = 2'd0,
        MEM_P = 2'd1,
        MEM_R = 2'd2
    } mem_sel_t;

    // one word written by the host per cycle with en high
    typedef struct packed
    {
        logic                     en;
        mem_sel_t                 sel;
        logic [`BICG_LOAD_AW-1:0] addr;
        logic [`BICG_DATA_W-1:0]  data;
    } load_req_t;

    // ##############################
    // result streams
    // ##############################

    // one word of the q or s stream, no back-pressure
    typedef struct packed
    {
        logic                    write;
        logic [`BICG_DATA_W-1:0] din;
    } result_beat_t;

endpackage

// ==== design/kernel_ram.sv ====
`include "bicg_cfg.svh"

module kernel_ram
    import bicg_pkg::*;
#(
    parameter mem_sel_t MEM_ID = MEM_A,
    parameter int       ADDR_W = `BICG_V_AW
)
(
    input  logic                    ap_clk,
    input  load_req_t               load,
    input  logic                    rd_en,
    input  logic [ADDR_W-1:0]       rd_addr,
    output logic [`BICG_DATA_W-1:0] rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [`BICG_DATA_W-1:0] mem [DEPTH];

    logic              wr_hit;
    logic [ADDR_W-1:0] wr_addr;

    // ##############################
    // host write side
    // ##############################

    // only words tagged for this memory land here
    assign wr_hit  = load.en && (load.sel == MEM_ID);
    assign wr_addr = load.addr[ADDR_W-1:0];

    always_ff @(posedge ap_clk)
    begin
        if (wr_hit)
        begin
            mem[wr_addr] <= load.data;
        end
    end

    // ##############################
    // kernel read side
    // ##############################

    // registered read, one cycle latency
    // output holds its last value until the next rd_en
    always_ff @(posedge ap_clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== design/bicg_core.sv ====
`include "bicg_cfg.svh"

module bicg_core
    import bicg_pkg::*;
(
    input  logic                    ap_clk,
    input  logic                    reset,
    input  logic                    ap_start,
    output logic                    ap_done,
    output logic                    ap_idle,

    output logic                    a_en,
    output logic [`BICG_A_AW-1:0]   a_addr,
    input  logic [`BICG_DATA_W-1:0] a_data,

    output logic                    p_en,
    output logic [`BICG_V_AW-1:0]   p_addr,
    input  logic [`BICG_DATA_W-1:0] p_data,

    output logic                    r_en,
    output logic [`BICG_V_AW-1:0]   r_addr,
    input  logic [`BICG_DATA_W-1:0] r_data,

    output result_beat_t            q_beat,
    output result_beat_t            s_beat
);

    localparam int DW = `BICG_DATA_W;
    localparam int VW = `BICG_V_AW;
    localparam int N  = `BICG_N;

    localparam logic [VW-1:0] LAST_IDX = VW'(N - 1);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_FETCH_R,
        S_ROW,
        S_DRAIN,
        S_SOUT,
        S_DONE
    } state_t;

    state_t state;

    logic [VW-1:0] row;
    logic [VW-1:0] col;

    // tracks the read in flight, data arrives one cycle later
    logic          mac_vld;
    logic [VW-1:0] mac_col;

    logic [DW-1:0] q_acc;
    logic [DW-1:0] s_acc [N];

    logic [DW-1:0] prod_q;
    logic [DW-1:0] prod_s;

    // ##############################
    // memory read requests
    // ##############################

    assign r_en   = (state == S_FETCH_R);
    assign r_addr = row;

    // A is row-major, so {row, col} is the word address
    assign a_en   = (state == S_ROW);
    assign a_addr = {row, col};
    assign p_en   = (state == S_ROW);
    assign p_addr = col;

    assign ap_idle = (state == S_IDLE);

    // products wrap to the data width
    // r_data stays put for the whole row since r_en fires once per row
    assign prod_q = a_data * p_data;
    assign prod_s = r_data * a_data;

    // ##############################
    // control FSM
    // ##############################

    always_ff @(posedge ap_clk)
    begin
        if (reset)
        begin
            state   <= S_IDLE;
            row     <= '0;
            col     <= '0;
            mac_vld <= 1'b0;
            mac_col <= '0;
            ap_done <= 1'b0;
        end
        else
        begin
            mac_vld <= (state == S_ROW);
            mac_col <= col;
            ap_done <= 1'b0;

            case (state)
                S_IDLE:
                begin
                    // start is ignored in every other state
                    if (ap_start)
                    begin
                        row   <= '0;
                        state <= S_FETCH_R;
                    end
                end

                S_FETCH_R:
                begin
                    col   <= '0;
                    state <= S_ROW;
                end

                S_ROW:
                begin
                    if (col == LAST_IDX)
                    begin
                        state <= S_DRAIN;
                    end
                    else
                    begin
                        col <= col + 1'b1;
                    end
                end

                S_DRAIN:
                begin
                    // last product of the row lands this cycle
                    if (row == LAST_IDX)
                    begin
                        col   <= '0;
                        state <= S_SOUT;
                    end
                    else
                    begin
                        row   <= row + 1'b1;
                        state <= S_FETCH_R;
                    end
                end

                S_SOUT:
                begin
                    if (col == LAST_IDX)
                    begin
                        state <= S_DONE;
                    end
                    else
                    begin
                        col <= col + 1'b1;
                    end
                end

                S_DONE:
                begin
                    // last s beat is on the wire now
                    ap_done <= 1'b1;
                    state   <= S_IDLE;
                end

                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // ##############################
    // accumulators and result beats
    // ##############################

    always_ff @(posedge ap_clk)
    begin
        if (reset)
        begin
            q_acc        <= '0;
            q_beat.write <= 1'b0;
            s_beat.write <= 1'b0;
            for (int k = 0; k < N; k++)
            begin
                s_acc[k] <= '0;
            end
        end
        else
        begin
            q_beat.write <= 1'b0;
            s_beat.write <= 1'b0;

            // column sums, one slot per column
            if (mac_vld)
            begin
                s_acc[mac_col] <= s_acc[mac_col] + prod_s;
            end

            // row sum goes out with its final product folded in
            if (state == S_DRAIN)
            begin
                q_beat.write <= 1'b1;
                q_beat.din   <= q_acc + prod_q;
                q_acc        <= '0;
            end
            else if (mac_vld)
            begin
                q_acc <= q_acc + prod_q;
            end

            // drain s, clearing each slot for the next run
            if (state == S_SOUT)
            begin
                s_beat.write <= 1'b1;
                s_beat.din   <= s_acc[col];
                s_acc[col]   <= '0;
            end
        end
    end

endmodule

// ==== design/result_fold.sv ====
`include "bicg_cfg.svh"

module result_fold
    import bicg_pkg::*;
(
    input  logic         ap_clk,
    input  logic         reset,
    input  result_beat_t q_beat,
    input  result_beat_t s_beat,
    output logic [3:0]   data_out,
    output logic         data_valid
);

    localparam int NBYTES = `BICG_DATA_W / 8;

    logic [7:0] q_byte;
    logic [7:0] s_byte;
    logic       q_vld;
    logic       s_vld;

    logic [7:0] mix_byte;
    logic       mix_vld;

    // xor of all bytes of one word
    function automatic logic [7:0] byte_fold(input logic [`BICG_DATA_W-1:0] word);
        logic [7:0] acc;
        acc = '0;
        for (int b = 0; b < NBYTES; b++)
        begin
            acc = acc ^ word[b*8 +: 8];
        end
        return acc;
    endfunction

    // ##############################
    // stage 1, per-stream byte fold
    // ##############################

    always_ff @(posedge ap_clk)
    begin
        if (reset)
        begin
            q_vld <= 1'b0;
            s_vld <= 1'b0;
        end
        else
        begin
            q_vld <= q_beat.write;
            s_vld <= s_beat.write;
        end
        q_byte <= byte_fold(q_beat.din);
        s_byte <= byte_fold(s_beat.din);
    end

    // ##############################
    // stage 2, merge the two streams
    // ##############################

    always_ff @(posedge ap_clk)
    begin
        if (reset)
        begin
            mix_vld <= 1'b0;
        end
        else
        begin
            mix_vld <= q_vld | s_vld;
        end

        case ({q_vld, s_vld})
            2'b01:   mix_byte <= s_byte;
            2'b10:   mix_byte <= q_byte;
            2'b11:   mix_byte <= q_byte ^ s_byte;
            default: mix_byte <= '0;
        endcase
    end

    // stage 3, nibble fold
    always_ff @(posedge ap_clk)
    begin
        if (reset)
        begin
            data_valid <= 1'b0;
        end
        else
        begin
            data_valid <= mix_vld;
        end
        data_out <= mix_byte[7:4] ^ mix_byte[3:0];
    end

endmodule

// ==== design/bicg_top.sv ====
`include "bicg_cfg.svh"

module bicg_top
    import bicg_pkg::*;
(
    input  logic       ap_clk,
    input  logic       reset,
    input  load_req_t  load,
    input  logic       ap_start,
    output logic       ap_done,
    output logic       ap_idle,
    output logic [3:0] data_out,
    output logic       data_valid
);

    // ##############################
    // kernel memory ports
    // ##############################

    logic                    a_en;
    logic [`BICG_A_AW-1:0]   a_addr;
    logic [`BICG_DATA_W-1:0] a_data;

    logic                    p_en;
    logic [`BICG_V_AW-1:0]   p_addr;
    logic [`BICG_DATA_W-1:0] p_data;

    logic                    r_en;
    logic [`BICG_V_AW-1:0]   r_addr;
    logic [`BICG_DATA_W-1:0] r_data;

    // result streams into the fold stage
    result_beat_t q_beat;
    result_beat_t s_beat;

    // ##############################
    // local memories
    // ##############################

    kernel_ram #(.MEM_ID(MEM_A), .ADDR_W(`BICG_A_AW)) a_ram
    (
        .ap_clk  (ap_clk),
        .load    (load),
        .rd_en   (a_en),
        .rd_addr (a_addr),
        .rd_data (a_data)
    );

    kernel_ram #(.MEM_ID(MEM_P), .ADDR_W(`BICG_V_AW)) p_ram
    (
        .ap_clk  (ap_clk),
        .load    (load),
        .rd_en   (p_en),
        .rd_addr (p_addr),
        .rd_data (p_data)
    );

    kernel_ram #(.MEM_ID(MEM_R), .ADDR_W(`BICG_V_AW)) r_ram
    (
        .ap_clk  (ap_clk),
        .load    (load),
        .rd_en   (r_en),
        .rd_addr (r_addr),
        .rd_data (r_data)
    );

    // ##############################
    // kernel and output fold
    // ##############################

    bicg_core kernel
    (
        .ap_clk   (ap_clk),
        .reset    (reset),
        .ap_start (ap_start),
        .ap_done  (ap_done),
        .ap_idle  (ap_idle),
        .a_en     (a_en),
        .a_addr   (a_addr),
        .a_data   (a_data),
        .p_en     (p_en),
        .p_addr   (p_addr),
        .p_data   (p_data),
        .r_en     (r_en),
        .r_addr   (r_addr),
        .r_data   (r_data),
        .q_beat   (q_beat),
        .s_beat   (s_beat)
    );

    result_fold fold
    (
        .ap_clk     (ap_clk),
        .reset      (reset),
        .q_beat     (q_beat),
        .s_beat     (s_beat),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

endmodule

// ==== testbench/bicg_tb.sv ====
`include "bicg_cfg.svh"

module bicg_tb
    import bicg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N            = `BICG_N;
    localparam int DW           = `BICG_DATA_W;
    localparam int LAW          = `BICG_LOAD_AW;
    localparam int RUN_TIMEOUT  = 1000;
    localparam int IDLE_TIMEOUT = 200;
    localparam int QUIET_CYCLES = 20;
    localparam logic [31:0] SEED = 32'h6c84cdfd;

    logic       ap_clk;
    logic       reset;
    load_req_t  load;
    logic       ap_start;
    logic       ap_done;
    logic       ap_idle;
    logic [3:0] data_out;
    logic       data_valid;

    // model copies of the three memories
    logic [DW-1:0] m_a [N*N];
    logic [DW-1:0] m_p [N];
    logic [DW-1:0] m_r [N];

    logic [3:0] exp_q [$];
    logic [3:0] exp_sig;
    logic [31:0] rng;
    string      run_name;

    int valid_count     = 0;
    int out_idx         = 0;
    int mismatch_errors = 0;
    int count_errors    = 0;
    int timeout_errors  = 0;

    bicg_top bicg_top_inst
    (
        .ap_clk     (ap_clk),
        .reset      (reset),
        .load       (load),
        .ap_start   (ap_start),
        .ap_done    (ap_done),
        .ap_idle    (ap_idle),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    initial
    begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // ##############################
    // random source and model
    // ##############################

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // bytes folded to one byte, then nibbles to one nibble
    function automatic logic [3:0] signature(input logic [DW-1:0] w);
        logic [7:0] b;
        b = w[7:0] ^ w[15:8] ^ w[23:16] ^ w[31:24];
        return b[7:4] ^ b[3:0];
    endfunction

    function automatic void fill_random();
        for (int i = 0; i < N*N; i++)
        begin
            m_a[i] = next_rand();
        end
        for (int i = 0; i < N; i++)
        begin
            m_p[i] = next_rand();
            m_r[i] = next_rand();
        end
    endfunction

    function automatic void fill_ones();
        for (int i = 0; i < N*N; i++)
        begin
            m_a[i] = '1;
        end
        for (int i = 0; i < N; i++)
        begin
            m_p[i] = '1;
            m_r[i] = '1;
        end
    endfunction

    // q rows first, then s columns, all mod 2^32
    function automatic void build_expected();
        logic [DW-1:0] acc;
        for (int i = 0; i < N; i++)
        begin
            acc = '0;
            for (int j = 0; j < N; j++)
            begin
                acc = acc + m_a[i*N + j] * m_p[j];
            end
            exp_q.push_back(signature(acc));
        end
        for (int j = 0; j < N; j++)
        begin
            acc = '0;
            for (int i = 0; i < N; i++)
            begin
                acc = acc + m_r[i] * m_a[i*N + j];
            end
            exp_q.push_back(signature(acc));
        end
    endfunction

    // ##############################
    // stimulus tasks
    // ##############################

    task automatic write_word(input mem_sel_t sel, input int addr, input logic [DW-1:0] data);
        load_req_t req;
        req.en   = 1'b1;
        req.sel  = sel;
        req.addr = LAW'(addr);
        req.data = data;
        @(posedge ap_clk);
        load <= req;
    endtask

    task automatic load_all();
        for (int i = 0; i < N*N; i++)
        begin
            write_word(MEM_A, i, m_a[i]);
        end
        for (int i = 0; i < N; i++)
        begin
            write_word(MEM_P, i, m_p[i]);
            write_word(MEM_R, i, m_r[i]);
        end
        @(posedge ap_clk);
        load <= '0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (!ap_idle && n < IDLE_TIMEOUT)
        begin
            @(posedge ap_clk);
            n++;
        end
        if (!ap_idle)
        begin
            $display("timeout at %0t: kernel never returned to idle", $time);
            timeout_errors++;
        end
    endtask

    task automatic check_reset_state();
        repeat (3)
        begin
            @(posedge ap_clk);
            if (!ap_idle || ap_done || data_valid)
            begin
                $display("after reset the kernel is not idle or an output is active");
                count_errors++;
            end
        end
    endtask

    task automatic run_kernel(input string name, input bit busy_start);
        int  base;
        int  n;
        int  extra_done;
        bit  seen;
        run_name   = name;
        extra_done = 0;
        wait_idle();
        build_expected();
        base = valid_count;
        @(posedge ap_clk);
        ap_start <= 1'b1;
        @(posedge ap_clk);
        ap_start <= 1'b0;

        // second start while the kernel is running
        if (busy_start)
        begin
            repeat (4) @(posedge ap_clk);
            if (ap_idle)
            begin
                $display("run %s: kernel idle when the busy start was issued", name);
                count_errors++;
            end
            ap_start <= 1'b1;
            @(posedge ap_clk);
            ap_start <= 1'b0;
        end

        seen = 1'b0;
        n    = 0;
        while (!seen && n < RUN_TIMEOUT)
        begin
            @(posedge ap_clk);
            n++;
            if (ap_done)
            begin
                seen = 1'b1;
            end
        end

        if (!seen)
        begin
            $display("timeout at %0t: ap_done never came in run %s", $time, name);
            timeout_errors++;
        end
        else
        begin
            if (!ap_idle)
            begin
                $display("run %s: ap_idle was low while ap_done was high", name);
                count_errors++;
            end
            // fold latency is three cycles, so the tail lands here
            repeat (3)
            begin
                @(posedge ap_clk);
                if (ap_done)
                begin
                    extra_done++;
                end
            end
            if (valid_count - base != 2*N)
            begin
                $display("run %s: %0d outputs by three cycles after ap_done, expected %0d",
                         name, valid_count - base, 2*N);
                count_errors++;
            end
        end

        // nothing more may happen once the run is over
        repeat (QUIET_CYCLES)
        begin
            @(posedge ap_clk);
            if (ap_done)
            begin
                extra_done++;
            end
        end
        if (extra_done != 0)
        begin
            $display("run %s: ap_done pulsed %0d extra times", name, extra_done);
            count_errors++;
        end
        if (valid_count - base != 2*N || exp_q.size() != 0)
        begin
            $display("run %s: got %0d outputs in total, expected %0d",
                     name, valid_count - base, 2*N);
            count_errors++;
            exp_q.delete();
        end
    endtask

    // ##############################
    // output monitor
    // ##############################

    always @(posedge ap_clk)
    begin
        if (!reset && data_valid)
        begin
            valid_count <= valid_count + 1;
            if (exp_q.size() == 0)
            begin
                $display("data_valid at %0t with no output expected", $time);
                count_errors++;
            end
            else
            begin
                exp_sig = exp_q.pop_front();
                if (data_out !== exp_sig)
                begin
                    $display("mismatch at %0t: run %s output %0d expected %h got %h",
                             $time, run_name, out_idx, exp_sig, data_out);
                    mismatch_errors++;
                end
            end
            out_idx++;
        end
    end

    // ##############################
    // main sequence
    // ##############################

    initial
    begin
        rng      = SEED;
        run_name = "reset";
        reset    = 1'b1;
        ap_start = 1'b0;
        load     = '0;

        repeat (3) @(posedge ap_clk);
        reset <= 1'b0;
        check_reset_state();

        fill_random();
        load_all();
        run_kernel("random", 1'b0);

        // every product is 1, so every word is N
        fill_ones();
        load_all();
        run_kernel("all ones", 1'b0);

        // fresh data right after a run, s slots must start from zero
        for (int k = 0; k < 3; k++)
        begin
            fill_random();
            load_all();
            run_kernel($sformatf("reload %0d", k), 1'b0);
        end

        fill_random();
        load_all();
        run_kernel("busy start", 1'b1);

        $display("error counts: mismatch %0d, count %0d, timeout %0d",
                 mismatch_errors, count_errors, timeout_errors);
        if (mismatch_errors + count_errors + timeout_errors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/bicg_pkg.sv
design/kernel_ram.sv
design/bicg_core.sv
design/result_fold.sv
design/bicg_top.sv
testbench/bicg_tb.sv
